//--- sys_cfg.svh
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

// number of compute tiles sharing the memory
`define SYS_NUM_TILES 4

// tile number prefixed to each memory address
`define SYS_TILE_ID_W 2

// word index inside one tile slice, 64 words per tile
`define SYS_TILE_WORD_W 6

// data path
`define SYS_DATA_W 32
`define SYS_SEL_W 4

// wishbone byte address as seen by a tile
`define SYS_ADR_W 32

// reset synchronizer depth
`define SYS_RST_STAGES 2

`endif

//--- sys_pkg.sv
`include "sys_cfg.svh"

package sys_pkg;

   typedef logic [`SYS_TILE_ID_W-1:0]   tile_id_t;
   typedef logic [`SYS_TILE_WORD_W-1:0] word_idx_t;

   // wishbone classic, master to slave
   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [`SYS_ADR_W-1:0]  adr;
      logic [`SYS_DATA_W-1:0] dat;
      logic [`SYS_SEL_W-1:0]  sel;
   } wb_req_t;

   // wishbone classic, slave to master
   typedef struct packed {
      logic                   ack;
      logic                   err;
      logic [`SYS_DATA_W-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      tile_id_t  tile;
      word_idx_t word;
   } tile_addr_t;

   // shared memory index, flat for the RAM, split by tile for the arbiter
   typedef union packed {
      logic [`SYS_TILE_ID_W+`SYS_TILE_WORD_W-1:0] flat;
      tile_addr_t                                tiled;
   } mem_addr_u;

   typedef struct packed {
      logic                   valid;
      logic                   we;
      mem_addr_u              addr;
      logic [`SYS_DATA_W-1:0] wdata;
      logic [`SYS_SEL_W-1:0]  sel;
   } mem_req_t;

   typedef struct packed {
      logic                   valid;
      logic                   we;
      word_idx_t              word;
      logic [`SYS_DATA_W-1:0] wdata;
      logic [`SYS_SEL_W-1:0]  sel;
   } tile_req_t;

   typedef struct packed {
      logic                   valid;
      tile_id_t               tile;
      logic [`SYS_DATA_W-1:0] rdata;
   } mem_rsp_t;

endpackage

//--- sys_reset_ctrl.sv
`include "sys_cfg.svh"

module sys_reset_ctrl (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic ctrl_logic_rst_i,
   input  logic com_rst_i,
   output logic sys_rst_n_o
);

   logic                       rst_req;
   logic [`SYS_RST_STAGES-1:0] sync_q;

   // board reset and both host requests all put the system in reset
   // the com reset is taken as a full reset too since there is no hot attach
   assign rst_req = !rst_n_i || ctrl_logic_rst_i || com_rst_i;

   // asserted at once, released through the flop chain
   always_ff @(posedge clk_i or posedge rst_req) begin
      if (rst_req) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[`SYS_RST_STAGES-2:0], 1'b1};
      end
   end

   assign sys_rst_n_o = sync_q[`SYS_RST_STAGES-1];

   // no clock cycle may see an active source with the system out of reset
   a_rst_follows_src: assert property (
      @(posedge clk_i) rst_req |-> !sys_rst_n_o
   ) else $error("system reset released while a reset source is active");

endmodule

//--- tile_mem_port.sv
`include "sys_cfg.svh"

module tile_mem_port import sys_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  wb_req_t   wb_req_i,
   output wb_rsp_t   wb_rsp_o,
   output tile_req_t tile_req_o,
   input  logic      grant_i,
   input  mem_rsp_t  mem_rsp_i
);

   // byte address bits that fall inside one tile slice
   localparam int SLICE_ADR_W = `SYS_TILE_WORD_W + 2;

   logic                   req_seen;
   logic                   in_range;
   logic                   pend_q;
   logic                   wait_q;
   logic                   ack_q;
   logic                   err_q;
   logic                   we_q;
   word_idx_t              word_q;
   logic [`SYS_DATA_W-1:0] wdata_q;
   logic [`SYS_SEL_W-1:0]  sel_q;
   logic [`SYS_DATA_W-1:0] rdata_q;

   // stb is still high in the ack/err cycle, so that cycle is not idle
   assign req_seen = wb_req_i.cyc && wb_req_i.stb &&
                     !pend_q && !wait_q && !ack_q && !err_q;

   // word aligned and inside the 64 word slice
   assign in_range = (wb_req_i.adr[`SYS_ADR_W-1:SLICE_ADR_W] == '0) &&
                     (wb_req_i.adr[1:0] == 2'b00);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q <= 1'b0;
         wait_q <= 1'b0;
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         if (req_seen) begin
            pend_q <= in_range;
            err_q  <= !in_range;
         end
         if (pend_q && grant_i) begin
            pend_q <= 1'b0;
            wait_q <= 1'b1;
         end
         if (wait_q && mem_rsp_i.valid) begin
            wait_q <= 1'b0;
            ack_q  <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_seen) begin
         we_q    <= wb_req_i.we;
         word_q  <= wb_req_i.adr[SLICE_ADR_W-1:2];
         wdata_q <= wb_req_i.dat;
         sel_q   <= wb_req_i.sel;
      end
      if (wait_q && mem_rsp_i.valid) begin
         rdata_q <= mem_rsp_i.rdata;
      end
   end

   assign tile_req_o = '{valid: pend_q, we: we_q, word: word_q, wdata: wdata_q, sel: sel_q};
   assign wb_rsp_o   = '{ack: ack_q, err: err_q, dat: rdata_q};

   a_ack_err_excl: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(wb_rsp_o.ack && wb_rsp_o.err)
   ) else $error("ack and err high together");

endmodule

//--- mem_interconnect.sv
`include "sys_cfg.svh"

module mem_interconnect import sys_pkg::*; (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  tile_req_t                 tile_req_i [`SYS_NUM_TILES],
   output logic [`SYS_NUM_TILES-1:0] grant_o,
   output mem_req_t                  mem_req_o,
   input  mem_rsp_t                  mem_rsp_i,
   output mem_rsp_t                  tile_rsp_o [`SYS_NUM_TILES]
);

   localparam int N     = `SYS_NUM_TILES;
   localparam int TID_W = `SYS_TILE_ID_W;

   logic [N-1:0]           req_vec;
   logic [TID_W-1:0]       rr_ptr_q;
   logic [TID_W-1:0]       cand;
   logic [TID_W-1:0]       win_idx;
   logic                   win_found;
   logic [N-1:0]           grant_q;
   logic                   mem_valid_q;
   logic                   mem_we_q;
   mem_addr_u              mem_addr_q;
   logic [`SYS_DATA_W-1:0] mem_wdata_q;
   logic [`SYS_SEL_W-1:0]  mem_sel_q;

   // the tile granted last cycle still shows valid, so it sits this one out
   always_comb begin
      for (int i = 0; i < N; i++) begin
         req_vec[i] = tile_req_i[i].valid && !grant_q[i];
      end
   end

   // round robin, search starts at the tile after the last winner
   always_comb begin
      win_found = 1'b0;
      win_idx   = '0;
      cand      = rr_ptr_q;
      for (int i = 0; i < N; i++) begin
         cand = rr_ptr_q + TID_W'(i);
         if (!win_found && req_vec[cand]) begin
            win_found = 1'b1;
            win_idx   = cand;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rr_ptr_q    <= '0;
         grant_q     <= '0;
         mem_valid_q <= 1'b0;
      end else begin
         grant_q     <= '0;
         mem_valid_q <= win_found;
         if (win_found) begin
            grant_q[win_idx] <= 1'b1;
            rr_ptr_q         <= win_idx + 1'b1;
         end
      end
   end

   // prefix the tile number, like the two tile bits in front of a DDR address
   always_ff @(posedge clk_i) begin
      if (win_found) begin
         mem_we_q              <= tile_req_i[win_idx].we;
         mem_addr_q.tiled.tile <= win_idx;
         mem_addr_q.tiled.word <= tile_req_i[win_idx].word;
         mem_wdata_q           <= tile_req_i[win_idx].wdata;
         mem_sel_q             <= tile_req_i[win_idx].sel;
      end
   end

   assign grant_o   = grant_q;
   assign mem_req_o = '{valid: mem_valid_q, we: mem_we_q, addr: mem_addr_q,
                        wdata: mem_wdata_q, sel: mem_sel_q};

   // responses go back to the tile named in the tag
   always_comb begin
      for (int t = 0; t < N; t++) begin
         tile_rsp_o[t].valid = mem_rsp_i.valid && (mem_rsp_i.tile == TID_W'(t));
         tile_rsp_o[t].tile  = mem_rsp_i.tile;
         tile_rsp_o[t].rdata = mem_rsp_i.rdata;
      end
   end

   a_grant_onehot: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) $onehot0(grant_o)
   ) else $error("more than one tile granted");

endmodule

//--- shared_mem.sv
`include "sys_cfg.svh"

module shared_mem import sys_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  mem_req_t mem_req_i,
   output mem_rsp_t mem_rsp_o
);

   localparam int MEM_WORDS = `SYS_NUM_TILES << `SYS_TILE_WORD_W;

   logic [`SYS_DATA_W-1:0] mem [MEM_WORDS];
   logic                   rsp_valid_q;
   tile_id_t               rsp_tile_q;
   logic [`SYS_DATA_W-1:0] rdata_q;

   // reads return the word as it was before a write in the same cycle
   always_ff @(posedge clk_i) begin
      if (mem_req_i.valid) begin
         rdata_q    <= mem[mem_req_i.addr.flat];
         rsp_tile_q <= mem_req_i.addr.tiled.tile;
         if (mem_req_i.we) begin
            for (int b = 0; b < `SYS_SEL_W; b++) begin
               if (mem_req_i.sel[b]) begin
                  mem[mem_req_i.addr.flat][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= mem_req_i.valid;
      end
   end

   assign mem_rsp_o = '{valid: rsp_valid_q, tile: rsp_tile_q, rdata: rdata_q};

   a_addr_known: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      mem_req_i.valid |-> !$isunknown(mem_req_i.addr)
   ) else $error("memory request with unknown address");

endmodule

//--- system_allct.sv
`include "sys_cfg.svh"

module system_allct import sys_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  logic    ctrl_logic_rst_i,
   input  logic    com_rst_i,
   input  wb_req_t wb_req_i [`SYS_NUM_TILES],
   output wb_rsp_t wb_rsp_o [`SYS_NUM_TILES]
);

   logic                      sys_rst_n;
   tile_req_t                 tile_req [`SYS_NUM_TILES];
   logic [`SYS_NUM_TILES-1:0] grant;
   mem_rsp_t                  tile_rsp [`SYS_NUM_TILES];
   mem_req_t                  mem_req;
   mem_rsp_t                  mem_rsp;

   sys_reset_ctrl u_reset (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .ctrl_logic_rst_i (ctrl_logic_rst_i),
      .com_rst_i        (com_rst_i),
      .sys_rst_n_o      (sys_rst_n)
   );

   // one memory port per compute tile
   for (genvar t = 0; t < `SYS_NUM_TILES; t++) begin : g_tile
      tile_mem_port u_port (
         .clk_i      (clk_i),
         .rst_n_i    (sys_rst_n),
         .wb_req_i   (wb_req_i[t]),
         .wb_rsp_o   (wb_rsp_o[t]),
         .tile_req_o (tile_req[t]),
         .grant_i    (grant[t]),
         .mem_rsp_i  (tile_rsp[t])
      );
   end

   mem_interconnect u_interconnect (
      .clk_i      (clk_i),
      .rst_n_i    (sys_rst_n),
      .tile_req_i (tile_req),
      .grant_o    (grant),
      .mem_req_o  (mem_req),
      .mem_rsp_i  (mem_rsp),
      .tile_rsp_o (tile_rsp)
   );

   // on-chip stand-in for the DDR
   shared_mem u_mem (
      .clk_i     (clk_i),
      .rst_n_i   (sys_rst_n),
      .mem_req_i (mem_req),
      .mem_rsp_o (mem_rsp)
   );

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD = 10;
   localparam int RST_CYCLES  = 10;

   initial clk_o = 1'b0;

   always #(HALF_PERIOD) clk_o = ~clk_o;

   // board reset held low for the first cycles
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

//--- tb_system_allct.sv
`include "sys_cfg.svh"

module tb_system_allct import sys_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N           = `SYS_NUM_TILES;
   localparam int SLICE_W     = `SYS_TILE_WORD_W + 2;
   localparam int WR_PER_TILE = 8;
   localparam int RST_HOLD    = 16;
   // accesses of tests 1 to 5 in order are 2*8 per tile, 5, 8, 5 and 2*3
   localparam int NUM_ACCESSES   = N * 2 * WR_PER_TILE + 5 + 8 + 5 + 6;
   localparam int TIMEOUT_CYCLES = 64 * NUM_ACCESSES;

   typedef struct packed {
      logic [`SYS_TILE_ID_W-1:0] tile;
      logic                      is_read;
      wb_rsp_t                   got;
      wb_rsp_t                   exp;
   } result_t;

   logic                   clk;
   logic                   rst_n;
   logic                   ctrl_logic_rst;
   logic                   com_rst;
   wb_req_t                wb_req [N];
   wb_rsp_t                wb_rsp [N];
   logic [`SYS_DATA_W-1:0] ref_mem [N][1 << `SYS_TILE_WORD_W];
   logic [5:0]             widx [WR_PER_TILE];
   logic [`SYS_DATA_W-1:0] cc_data [N];
   result_t                res_q [$];
   result_t                cur_res;
   integer                 seed = 32'h90e6;
   int                     err_cnt = 0;
   int                     check_cnt = 0;
   int                     test_cnt = 0;
   int                     fail_cnt = 0;
   int                     test_err0 = 0;
   int                     cycle_cnt = 0;

   tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   system_allct DUT (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .ctrl_logic_rst_i (ctrl_logic_rst),
      .com_rst_i        (com_rst),
      .wb_req_i         (wb_req),
      .wb_rsp_o         (wb_rsp)
   );

   // a tile owns 64 words and byte addresses must be word aligned
   function automatic wb_rsp_t expect_read(input int t, input logic [31:0] adr);
      wb_rsp_t r;
      r = '0;
      if (adr >= (32'd1 << SLICE_W) || adr[1:0] != 2'b00) begin
         r.err = 1'b1;
      end else begin
         r.ack = 1'b1;
         r.dat = ref_mem[t][adr[SLICE_W-1:2]];
      end
      return r;
   endfunction

   task automatic ref_write(input int t, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      for (int b = 0; b < `SYS_SEL_W; b++) begin
         if (sel[b]) ref_mem[t][adr[SLICE_W-1:2]][8*b +: 8] = dat[8*b +: 8];
      end
   endtask

   task automatic check_data(input string name, input wb_rsp_t got, input wb_rsp_t exp,
                             input logic with_dat);
      if (got.ack !== exp.ack) begin
         $display("ERR t=%0t %s.ack got %0b exp %0b", $time, name, got.ack, exp.ack);
         err_cnt++;
      end
      if (with_dat && got.dat !== exp.dat) begin
         $display("ERR t=%0t %s.dat got %08h exp %08h", $time, name, got.dat, exp.dat);
         err_cnt++;
      end
   endtask

   task automatic check_err(input string name, input wb_rsp_t got, input wb_rsp_t exp);
      if (got.err !== exp.err || got.ack !== exp.ack) begin
         $display("ERR t=%0t %s.err/ack got %0b/%0b exp %0b/%0b", $time, name,
                  got.err, got.ack, exp.err, exp.ack);
         err_cnt++;
      end
   endtask

   task automatic start_access(input int t, input logic we, input logic [31:0] adr,
                               input logic [31:0] dat, input logic [3:0] sel);
      @(posedge clk);
      wb_req[t] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
   endtask

   // sampled on the falling edge away from the DUT's flop updates
   task automatic wait_response(input int t, output wb_rsp_t got);
      do @(negedge clk); while (!(wb_rsp[t].ack || wb_rsp[t].err));
      got = wb_rsp[t];
   endtask

   task automatic end_access(input int t);
      @(posedge clk);
      wb_req[t] <= '0;
   endtask

   task automatic do_access(input int t, input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel);
      wb_rsp_t exp;
      wb_rsp_t got;
      exp = expect_read(t, adr);
      if (we && !exp.err) ref_write(t, adr, dat, sel);
      start_access(t, we, adr, dat, sel);
      wait_response(t, got);
      end_access(t);
      res_q.push_back(result_t'{tile: t[1:0], is_read: !we, got: got, exp: exp});
   endtask

   // request raised while a host reset source is high
   task automatic reset_pass(input int src, input int t);
      wb_rsp_t exp;
      wb_rsp_t got;
      do_access(t, 1'b1, 32'h50, $random(seed), 4'hf);
      exp = expect_read(t, 32'h50);
      @(posedge clk);
      if (src == 0) ctrl_logic_rst <= 1'b1;
      else com_rst <= 1'b1;
      start_access(t, 1'b0, 32'h50, '0, '0);
      repeat (RST_HOLD) begin
         @(negedge clk);
         if (wb_rsp[t].ack || wb_rsp[t].err) begin
            $display("t=%0t tile %0d answered while the host reset was held", $time, t);
            err_cnt++;
         end
      end
      @(posedge clk);
      ctrl_logic_rst <= 1'b0;
      com_rst        <= 1'b0;
      wait_response(t, got);
      end_access(t);
      res_q.push_back(result_t'{tile: t[1:0], is_read: 1'b1, got: got, exp: exp});
      do_access(3, 1'b0, 32'hfc, '0, '0);
   endtask

   task automatic finish_test(input string name);
      while (res_q.size() != 0) @(posedge clk);
      test_cnt++;
      if (err_cnt != test_err0) fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
      test_err0 = err_cnt;
   endtask

   always @(posedge clk) begin
      while (res_q.size() > 0) begin
         cur_res = res_q.pop_front();
         check_cnt++;
         if (cur_res.exp.err) begin
            check_err($sformatf("wb_rsp_o[%0d]", cur_res.tile), cur_res.got, cur_res.exp);
         end else begin
            check_data($sformatf("wb_rsp_o[%0d]", cur_res.tile), cur_res.got, cur_res.exp,
                       cur_res.is_read);
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, an access never got ack or err", cycle_cnt);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial begin
      for (int t = 0; t < N; t++) wb_req[t] = '0;
      ctrl_logic_rst = 1'b0;
      com_rst        = 1'b0;
      wait (rst_n === 1'b1);
      repeat (`SYS_RST_STAGES + 2) @(posedge clk);

      for (int t = 0; t < N; t++) begin
         for (int i = 0; i < WR_PER_TILE; i++) begin
            widx[i] = 6'($random(seed));
            do_access(t, 1'b1, {24'h0, widx[i], 2'b00}, $random(seed), 4'hf);
         end
         for (int i = 0; i < WR_PER_TILE; i++) begin
            do_access(t, 1'b0, {24'h0, widx[i], 2'b00}, '0, '0);
         end
      end
      finish_test("write then read per tile");

      do_access(2, 1'b1, 32'h14, 32'h1122_3344, 4'hf);
      do_access(2, 1'b1, 32'h14, 32'haabb_ccdd, 4'b0101);
      do_access(2, 1'b0, 32'h14, '0, '0);
      do_access(2, 1'b1, 32'h14, 32'h5566_7788, 4'b1000);
      do_access(2, 1'b0, 32'h14, '0, '0);
      finish_test("byte selects");

      for (int t = 0; t < N; t++) cc_data[t] = $random(seed);
      fork
         do_access(0, 1'b1, 32'hfc, cc_data[0], 4'hf);
         do_access(1, 1'b1, 32'hfc, cc_data[1], 4'hf);
         do_access(2, 1'b1, 32'hfc, cc_data[2], 4'hf);
         do_access(3, 1'b1, 32'hfc, cc_data[3], 4'hf);
      join
      fork
         do_access(0, 1'b0, 32'hfc, '0, '0);
         do_access(1, 1'b0, 32'hfc, '0, '0);
         do_access(2, 1'b0, 32'hfc, '0, '0);
         do_access(3, 1'b0, 32'hfc, '0, '0);
      join
      finish_test("isolation and concurrency");

      do_access(3, 1'b1, 32'h0, $random(seed), 4'hf);
      do_access(3, 1'b1, 32'h100, $random(seed), 4'hf);
      do_access(3, 1'b0, 32'h104, '0, '0);
      do_access(3, 1'b1, 32'h0001_0000, $random(seed), 4'hf);
      do_access(3, 1'b0, 32'h0, '0, '0);
      finish_test("out of range address");

      reset_pass(0, 0);
      reset_pass(1, 1);
      finish_test("host reset");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
sys_pkg.sv
sys_reset_ctrl.sv
tile_mem_port.sv
mem_interconnect.sv
shared_mem.sv
system_allct.sv
tb_clk_gen.sv
tb_system_allct.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f filelist.f --top-module tb_system_allct --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "=== PASS ===" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
